// ==== rtl/trace_config.svh ====
/*
 * Trace front end configuration
 * Window and rule sizes, ARM sync frame words, FIFO record
 * field layout and downstream credit depth.
 */

`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// capture window and rule set
`define TRACE_BUF_WIDTH         64
`define TRACE_MATCH_RULES       8
`define TRACE_COUNT_WIDTH       8

// sync frame, top 16 bits and low byte of the reversed window
`define TRACE_SYNC_HEAD         16'h7fff
`define TRACE_SYNC_TAIL         8'hff

// timestamps carried in records
`define TRACE_SHORT_TIME_WIDTH  8
`define TRACE_FULL_TIME_WIDTH   16

// record layout: cmd | time | rule bits
`define TRACE_REC_WIDTH         18
`define TRACE_REC_CMD_START     16
`define TRACE_REC_TIME_START    8
`define TRACE_REC_DATA_START    0

// slots in the downstream FIFO
`define TRACE_CREDITS           4

`endif

// ==== rtl/trace_pkg.sv ====
/*
 * Trace front end types
 * Vector types for the window, rule bits, counters,
 * timestamps and records, plus the record command and
 * packer state encodings.
 */

`include "trace_config.svh"

package trace_pkg;

   // datapath vectors
   typedef logic [`TRACE_BUF_WIDTH-1:0]        trace_buf_t;
   typedef logic [2:0]                         trace_width_t;
   typedef logic [`TRACE_MATCH_RULES-1:0]      rule_bits_t;
   typedef logic [`TRACE_COUNT_WIDTH-1:0]      match_count_t;

   // timestamps and records
   typedef logic [`TRACE_SHORT_TIME_WIDTH-1:0] short_time_t;
   typedef logic [`TRACE_FULL_TIME_WIDTH-1:0]  full_time_t;
   typedef logic [`TRACE_REC_WIDTH-1:0]        trace_rec_t;

   // holds 0 .. TRACE_CREDITS
   typedef logic [2:0]                         credit_t;

   // record command field, STAT kept reserved
   typedef enum logic [1:0] {
      CMD_DATA = 2'd0,
      CMD_TIME = 2'd1,
      CMD_STAT = 2'd2
   } rec_cmd_e;

   typedef enum logic [1:0] {
      PK_IDLE,
      PK_SEND_TIME,
      PK_SEND_DATA
   } packer_state_e;

endpackage

// ==== rtl/trace_shifter.sv ====
/*
 * Trace shifter
 * Shifts 1, 2 or 4 trace bits per fe_clk into a 64-bit
 * window and presents it bit-reversed for big-endian compares.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module trace_shifter (
   input  logic                    fe_clk,
   input  logic                    reset,
   input  logic [3:0]              trace_data,
   input  trace_pkg::trace_width_t trace_width,
   output trace_pkg::trace_buf_t   window
);

   import trace_pkg::*;

   // raw shift register, newest bits at the bottom
   trace_buf_t buffer;

   ////////////////////////////////////////
   // shift in
   ////////////////////////////////////////

   // trace_data[0] is the oldest pin sample
   // so it lands above the later bits
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         buffer <= '0;
      end else begin
         case (trace_width)
            3'd4: begin
               buffer <= {buffer[`TRACE_BUF_WIDTH-5:0],
                          trace_data[0], trace_data[1],
                          trace_data[2], trace_data[3]};
            end
            3'd2: begin
               buffer <= {buffer[`TRACE_BUF_WIDTH-3:0],
                          trace_data[0], trace_data[1]};
            end
            // width 1 and any illegal code
            default: begin
               buffer <= {buffer[`TRACE_BUF_WIDTH-2:0], trace_data[0]};
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // endianness fix
   ////////////////////////////////////////

   // plain bit reversal of the whole window
   always_comb begin
      for (int i = 0; i < `TRACE_BUF_WIDTH; i++) begin
         window[i] = buffer[`TRACE_BUF_WIDTH-1-i];
      end
   end

endmodule

// ==== rtl/trace_sync.sv ====
/*
 * Trace sync lock
 * Locks onto ARM sync frames in the window, drops lock on
 * resync or a trace width change, and strobes the cycles
 * where the window sits on a byte boundary.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module trace_sync (
   input  logic                    fe_clk,
   input  logic                    reset,
   input  trace_pkg::trace_buf_t   window,
   input  trace_pkg::trace_width_t trace_width,
   input  logic                    resync,
   output logic                    synchronized,
   output logic                    byte_valid
);

   import trace_pkg::*;

   trace_width_t width_r;
   logic [2:0]   phase;
   logic         width_changed;
   logic         frame_seen;

   assign width_changed = (trace_width != width_r);

   // head and tail together also catch half sync frames
   assign frame_seen = (window[`TRACE_BUF_WIDTH-1 -: 16] == `TRACE_SYNC_HEAD) &&
                       (window[7:0] == `TRACE_SYNC_TAIL);

   ////////////////////////////////////////
   // lock state and phase
   ////////////////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         synchronized <= 1'b0;
         phase        <= '0;
         width_r      <= '0;
      end else begin
         width_r <= trace_width;
         // loss wins over a fresh frame in the same cycle
         if (resync || width_changed) begin
            synchronized <= 1'b0;
            phase        <= '0;
         end else if (!synchronized && frame_seen) begin
            synchronized <= 1'b1;
            phase        <= 3'd1;
         end else if (synchronized) begin
            // free-running, wrap is intended
            phase <= phase + 3'd1;
         end
      end
   end

   // one byte every 8/width cycles
   always_comb begin
      case (trace_width)
         3'd1:    byte_valid = synchronized && (phase == 3'd0);
         3'd2:    byte_valid = synchronized && (phase[1:0] == 2'd0);
         3'd4:    byte_valid = synchronized && !phase[0];
         default: byte_valid = 1'b0;
      endcase
   end

endmodule

// ==== rtl/trace_matcher.sv ====
/*
 * Trace pattern matcher
 * Compares the window against eight masked rules on each
 * byte-aligned cycle, counts hits per rule, keeps the last
 * matched window and raises the armed trigger on a new match.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module trace_matcher (
   input  logic                    fe_clk,
   input  logic                    reset,
   input  trace_pkg::trace_buf_t   window,
   input  logic                    byte_valid,
   input  logic                    capturing,
   input  logic                    arm,
   input  trace_pkg::rule_bits_t   rule_enable,
   input  trace_pkg::rule_bits_t   rule_trig_enable,
   input  trace_pkg::trace_buf_t   rule_pattern [`TRACE_MATCH_RULES],
   input  trace_pkg::trace_buf_t   rule_mask [`TRACE_MATCH_RULES],
   output trace_pkg::rule_bits_t   match_bits,
   output logic                    match_strobe,
   output trace_pkg::match_count_t match_count [`TRACE_MATCH_RULES],
   output trace_pkg::trace_buf_t   matched_data,
   output logic                    trigger_match
);

   import trace_pkg::*;

   rule_bits_t hit;
   logic       trig_now;
   logic       trig_prev;

   // all rules in parallel
   // trigger-enabled rules still fire outside capture
   always_comb begin
      for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
         hit[i] = byte_valid && rule_enable[i] &&
                  ((window & rule_mask[i]) == (rule_pattern[i] & rule_mask[i])) &&
                  (capturing || rule_trig_enable[i]);
      end
   end

   ////////////////////////////////////////
   // match bits, strobe, counters
   ////////////////////////////////////////

   // match_bits hold between aligned cycles
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         match_bits   <= '0;
         match_strobe <= 1'b0;
         for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
            match_count[i] <= '0;
         end
      end else begin
         // only capturing hits become records
         match_strobe <= capturing && (|hit);
         if (byte_valid) begin
            match_bits <= hit;
         end
         for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
            if (hit[i]) begin
               match_count[i] <= match_count[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (|hit) begin
         matched_data <= window;
      end
   end

   ////////////////////////////////////////
   // trigger edge
   ////////////////////////////////////////

   assign trig_now = |(match_bits & rule_trig_enable);

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         trig_prev     <= 1'b0;
         trigger_match <= 1'b0;
      end else begin
         trig_prev     <= trig_now;
         // none-to-some transition only
         trigger_match <= arm && trig_now && !trig_prev;
      end
   end

endmodule

// ==== rtl/trace_packer.sv ====
/*
 * Trace record packer
 * Times the gap between DATA records, turns each capture
 * match into an optional TIME record plus a DATA record,
 * and paces output by the downstream FIFO credits.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module trace_packer (
   input  logic                  fe_clk,
   input  logic                  reset,
   input  trace_pkg::rule_bits_t match_bits,
   input  logic                  match_strobe,
   input  logic                  rec_credit,
   output logic                  rec_valid,
   output trace_pkg::trace_rec_t rec_data,
   output logic                  rec_overflow
);

   import trace_pkg::*;

   packer_state_e state;
   credit_t       credits;
   full_time_t    gap_timer;
   full_time_t    pend_gap;
   rule_bits_t    pend_bits;
   trace_rec_t    time_rec;
   trace_rec_t    data_rec;
   logic          can_send;
   logic          send_time;
   logic          send_data;
   logic          gap_long;

   // a record already on rec_valid still owes its credit
   assign can_send  = (credits > credit_t'(rec_valid));
   assign send_time = (state == PK_SEND_TIME) && can_send;
   assign send_data = (state == PK_SEND_DATA) && can_send;
   // gap too wide for the short field
   assign gap_long  = (gap_timer > full_time_t'((1 << `TRACE_SHORT_TIME_WIDTH) - 1));

   ////////////////////////////////////////
   // record formats
   ////////////////////////////////////////

   always_comb begin
      time_rec = '0;
      time_rec[`TRACE_REC_CMD_START +: $bits(rec_cmd_e)]       = CMD_TIME;
      time_rec[`TRACE_REC_DATA_START +: `TRACE_FULL_TIME_WIDTH] = pend_gap;
      data_rec = '0;
      data_rec[`TRACE_REC_CMD_START +: $bits(rec_cmd_e)]         = CMD_DATA;
      data_rec[`TRACE_REC_TIME_START +: `TRACE_SHORT_TIME_WIDTH] =
         pend_gap[`TRACE_SHORT_TIME_WIDTH-1:0];
      data_rec[`TRACE_REC_DATA_START +: `TRACE_MATCH_RULES]      = pend_bits;
   end

   ////////////////////////////////////////
   // FSM and overflow
   ////////////////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         state        <= PK_IDLE;
         rec_valid    <= 1'b0;
         rec_overflow <= 1'b0;
      end else begin
         rec_valid <= send_time || send_data;
         case (state)
            PK_IDLE:      if (match_strobe) state <= gap_long ? PK_SEND_TIME : PK_SEND_DATA;
            PK_SEND_TIME: if (can_send) state <= PK_SEND_DATA;
            PK_SEND_DATA: if (can_send) state <= PK_IDLE;
            default:      state <= PK_IDLE;
         endcase
         // slot busy, this match is lost, sticky until reset
         if (match_strobe && (state != PK_IDLE)) begin
            rec_overflow <= 1'b1;
         end
      end
   end

   // pending slot, gap cleared once TIME has carried it
   always_ff @(posedge fe_clk) begin
      if ((state == PK_IDLE) && match_strobe) begin
         pend_bits <= match_bits;
         pend_gap  <= gap_timer;
      end else if (send_time) begin
         pend_gap <= '0;
      end
      if (send_time) begin
         rec_data <= time_rec;
      end else if (send_data) begin
         rec_data <= data_rec;
      end
   end

   ////////////////////////////////////////
   // gap timer and credits
   ////////////////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         gap_timer <= '0;
         credits   <= credit_t'(`TRACE_CREDITS);
      end else begin
         // restart at each DATA record, saturate at 16 bits
         if (send_data) begin
            gap_timer <= '0;
         end else if (gap_timer != '1) begin
            gap_timer <= gap_timer + 1'b1;
         end
         // spend and return in one cycle cancel
         case ({rec_valid, rec_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   if (credits != credit_t'(`TRACE_CREDITS)) credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

// ==== rtl/trace_frontend.sv ====
/*
 * ARM parallel trace capture front end
 * Shifter, sync lock, pattern matcher and record packer
 * chained in the fe_clk domain.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module trace_frontend (
   input  logic                    fe_clk,
   input  logic                    reset,
   // trace port
   input  logic [3:0]              trace_data,
   input  trace_pkg::trace_width_t trace_width,
   // control
   input  logic                    resync,
   input  logic                    capturing,
   input  logic                    arm,
   input  trace_pkg::rule_bits_t   rule_enable,
   input  trace_pkg::rule_bits_t   rule_trig_enable,
   input  trace_pkg::trace_buf_t   rule_pattern [`TRACE_MATCH_RULES],
   input  trace_pkg::trace_buf_t   rule_mask [`TRACE_MATCH_RULES],
   // FIFO credit return
   input  logic                    rec_credit,
   // status
   output logic                    synchronized,
   output trace_pkg::match_count_t match_count [`TRACE_MATCH_RULES],
   output trace_pkg::trace_buf_t   matched_data,
   output logic                    trigger_match,
   // record stream
   output logic                    rec_valid,
   output trace_pkg::trace_rec_t   rec_data,
   output logic                    rec_overflow
);

   import trace_pkg::*;

   trace_buf_t window;
   logic       byte_valid;
   rule_bits_t match_bits;
   logic       match_strobe;

   trace_shifter trace_shifter_inst (
      .fe_clk      (fe_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .trace_width (trace_width),
      .window      (window)
   );

   trace_sync trace_sync_inst (
      .fe_clk       (fe_clk),
      .reset        (reset),
      .window       (window),
      .trace_width  (trace_width),
      .resync       (resync),
      .synchronized (synchronized),
      .byte_valid   (byte_valid)
   );

   trace_matcher trace_matcher_inst (
      .fe_clk           (fe_clk),
      .reset            (reset),
      .window           (window),
      .byte_valid       (byte_valid),
      .capturing        (capturing),
      .arm              (arm),
      .rule_enable      (rule_enable),
      .rule_trig_enable (rule_trig_enable),
      .rule_pattern     (rule_pattern),
      .rule_mask        (rule_mask),
      .match_bits       (match_bits),
      .match_strobe     (match_strobe),
      .match_count      (match_count),
      .matched_data     (matched_data),
      .trigger_match    (trigger_match)
   );

   trace_packer trace_packer_inst (
      .fe_clk       (fe_clk),
      .reset        (reset),
      .match_bits   (match_bits),
      .match_strobe (match_strobe),
      .rec_credit   (rec_credit),
      .rec_valid    (rec_valid),
      .rec_data     (rec_data),
      .rec_overflow (rec_overflow)
   );

endmodule

// ==== tests/tb_trace_tests.svh ====
/*
 * Directed tests for the trace front end
 * Sync lock, masked matching, trigger, record format
 * and credit back-pressure.
 */

task automatic send_byte(input logic [7:0] b);
   // low nibble first at width 4
   drive_cycle(b[3:0], 1'b0);
   drive_cycle(b[7:4], 1'b0);
endtask

// all ones, then the newest bit low
task automatic send_sync(input int w);
   logic [3:0] frame;
   cfg_width = trace_width_t'(w);
   repeat (64 / w + 2) drive_cycle(4'hf, 1'b0);
   frame = 4'hf & ~(4'b0001 << (w - 1));
   drive_cycle(frame, 1'b0);
endtask

task automatic wait_synced(input int limit);
   int n;
   n = 0;
   while (!synchronized) begin
      if (n >= limit) fail_run("synchronized did not rise after a sync frame");
      drive_cycle(4'hf, 1'b0);
      n++;
   end
endtask

task automatic wait_records(input int count, input int limit);
   int n;
   n = 0;
   // idle in whole bytes so the byte phase holds
   while (rec_q.size() < count) begin
      if (n >= limit) fail_run("expected records did not arrive");
      send_byte(8'h00);
      n++;
   end
endtask

task automatic check_data_rec(input trace_rec_t rec);
   check("rec_data cmd", rec[17:16], CMD_DATA);
   if (m_exp_q.size() == 0) fail_run("DATA record without a capturing match");
   check("rec_data rule bits", rec[7:0], m_exp_q.pop_front());
endtask

//////////////////////////////////////////
// tests
//////////////////////////////////////////

task automatic sync_lock_test();
   send_sync(1);
   wait_synced(16);
   // width change drops lock
   cfg_width = 3'd2;
   drive_cycle(4'hf, 1'b0);
   check("synchronized", synchronized, 1'b0);
   send_sync(2);
   wait_synced(16);
   cfg_resync = 1'b1;
   drive_cycle(4'hf, 1'b0);
   cfg_resync = 1'b0;
   check("synchronized", synchronized, 1'b0);
   send_sync(4);
   wait_synced(16);
   cfg_width = 3'd1;
   drive_cycle(4'hf, 1'b0);
   check("synchronized", synchronized, 1'b0);
endtask

task automatic match_count_test();
   logic [7:0] b;
   // rule0 newest byte, rule1 two bytes, rule2 one nibble
   cfg_mask[0]    = {8'hff, 56'h0};
   cfg_pattern[0] = {8'ha5, 56'h0};
   cfg_mask[1]    = {16'hffff, 48'h0};
   cfg_pattern[1] = {16'hc33c, 48'h0};
   cfg_mask[2]    = {8'h0f, 56'h0};
   cfg_pattern[2] = {8'h35, 56'h0};
   cfg_enable = 8'h07;
   cfg_trig   = 8'h07;
   send_sync(4);
   for (int n = 0; n < 40; n++) begin
      case (n % 5)
         0: send_byte(8'ha5);
         2: begin
            send_byte(8'h3c);
            send_byte(8'hc3);
         end
         default: begin
            b = 8'($random(seed));
            send_byte(b);
         end
      endcase
   end
   drive_cycle(4'h0, 1'b0);
   drive_cycle(4'h0, 1'b0);
   check("synchronized", synchronized, 1'b1);
   if (m_count[0] == 0) fail_run("planted pattern never matched");
   for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
      check($sformatf("match_count[%0d]", i), match_count[i], m_count[i]);
   end
   check("matched_data", matched_data, m_last_match);
endtask

task automatic trigger_test();
   cfg_enable = 8'h01;
   cfg_trig   = 8'h01;
   cfg_arm    = 1'b0;
   trig_pulses = 0;
   send_byte(8'ha5);
   send_byte(8'h00);
   send_byte(8'h00);
   check("trigger pulses while disarmed", trig_pulses, 0);
   cfg_arm = 1'b1;
   send_byte(8'h00);
   // one isolated match, then a persisting run
   send_byte(8'ha5);
   send_byte(8'h00);
   send_byte(8'ha5);
   send_byte(8'ha5);
   send_byte(8'ha5);
   send_byte(8'h00);
   send_byte(8'h00);
   check("trigger pulses while armed", trig_pulses, 2);
   cfg_arm  = 1'b0;
   cfg_trig = 8'h00;
endtask

task automatic record_format_test();
   trace_rec_t rec;
   cfg_capturing = 1'b1;
   auto_credit   = 1'b1;
   rec_q.delete();
   m_exp_q.delete();
   // long idle gap first
   repeat (320) drive_cycle(4'h0, 1'b0);
   send_byte(8'ha5);
   send_byte(8'h00);
   wait_records(2, 40);
   rec = rec_q.pop_front();
   check("rec_data cmd", rec[17:16], CMD_TIME);
   check("TIME gap at least 300", rec[15:0] >= 16'd300, 1'b1);
   check_data_rec(rec_q.pop_front());
   for (int n = 0; n < 4; n++) begin
      send_byte(8'ha5);
      send_byte(8'h00);
   end
   wait_records(4, 40);
   for (int n = 0; n < 4; n++) begin
      rec = rec_q.pop_front();
      check("short time small", rec[15:8] < 8'd16, 1'b1);
      check_data_rec(rec);
   end
   repeat (4) drive_cycle(4'h0, 1'b0);
   check("rec_overflow", rec_overflow, 1'b0);
endtask

task automatic credit_test();
   auto_credit = 1'b0;
   rec_q.delete();
   for (int n = 0; n < 6; n++) begin
      send_byte(8'ha5);
      send_byte(8'h00);
   end
   repeat (10) drive_cycle(4'h0, 1'b0);
   check("records without credits", rec_q.size(), 4);
   repeat (4) check_data_rec(rec_q.pop_front());
   check("rec_overflow", rec_overflow, 1'b1);
   // one slot back, pending 5th goes out
   drive_cycle(4'h0, 1'b1);
   wait_records(1, 20);
   check_data_rec(rec_q.pop_front());
   // 6th match was dropped
   m_exp_q.delete();
   repeat (10) drive_cycle(4'h0, 1'b0);
   check("records after one credit", rec_q.size(), 0);
   check("rec_overflow", rec_overflow, 1'b1);
endtask

// ==== tests/tb_trace_frontend.sv ====
/*
 * Trace front end testbench
 * Clock, reset, DUT, a window and sync model, the cycle
 * driver with record and trigger monitoring, and the
 * directed test sequence.
 */

`timescale 1ns/1ps
`include "trace_config.svh"

module tb_trace_frontend;

   import trace_pkg::*;

   logic         fe_clk;
   logic         reset;
   logic [3:0]   trace_data;
   trace_width_t trace_width;
   logic         resync;
   logic         capturing;
   logic         arm;
   rule_bits_t   rule_enable;
   rule_bits_t   rule_trig_enable;
   trace_buf_t   rule_pattern [`TRACE_MATCH_RULES];
   trace_buf_t   rule_mask [`TRACE_MATCH_RULES];
   logic         rec_credit;
   logic         synchronized;
   match_count_t match_count [`TRACE_MATCH_RULES];
   trace_buf_t   matched_data;
   logic         trigger_match;
   logic         rec_valid;
   trace_rec_t   rec_data;
   logic         rec_overflow;

   // next input values, applied on the falling edge
   trace_width_t cfg_width;
   logic         cfg_resync;
   logic         cfg_capturing;
   logic         cfg_arm;
   rule_bits_t   cfg_enable;
   rule_bits_t   cfg_trig;
   trace_buf_t   cfg_pattern [`TRACE_MATCH_RULES];
   trace_buf_t   cfg_mask [`TRACE_MATCH_RULES];

   // reference model of window, lock and matches
   trace_buf_t   m_window;
   logic         m_sync;
   int           m_phase;
   trace_width_t m_prev_width;
   match_count_t m_count [`TRACE_MATCH_RULES];
   trace_buf_t   m_last_match;
   rule_bits_t   m_exp_q [$];

   // observed records and pulses
   trace_rec_t   rec_q [$];
   int           rec_total;
   int           credit_total;
   int           trig_pulses;
   logic         auto_credit;
   int           error_count;
   integer       seed;

   trace_frontend trace_frontend_inst (.*);

   initial begin
      fe_clk = 1'b0;
      forever #20 fe_clk = ~fe_clk;
   end

   task automatic check(input string name, input logic [63:0] actual,
                        input logic [63:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_run(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("*** FAILED ***");
      $fatal(1, "run aborted");
   endtask

   ////////////////////////////////////////
   // one fe_clk cycle
   ////////////////////////////////////////

   // monitor, drive, then advance the model for the coming edge
   task automatic drive_cycle(input logic [3:0] data, input logic credit);
      rule_bits_t hits;
      logic       byte_ok;
      int         w;
      @(negedge fe_clk);
      if (rec_valid) begin
         rec_q.push_back(rec_data);
         rec_total++;
      end
      if (trigger_match) trig_pulses++;
      trace_data       = data;
      trace_width      = cfg_width;
      resync           = cfg_resync;
      capturing        = cfg_capturing;
      arm              = cfg_arm;
      rule_enable      = cfg_enable;
      rule_trig_enable = cfg_trig;
      rule_pattern     = cfg_pattern;
      rule_mask        = cfg_mask;
      // returned slot for every record seen when auto return is on
      rec_credit = credit || (auto_credit && rec_valid);
      if (rec_credit) credit_total++;
      if (rec_total - credit_total > `TRACE_CREDITS)
         fail_run("more records outstanding than FIFO credits");
      w = int'(trace_width);
      // byte boundary, a whole byte since the frame
      byte_ok = m_sync && ((m_phase * w) % 8 == 0);
      for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
         hits[i] = byte_ok && rule_enable[i] &&
                   ((m_window & rule_mask[i]) == (rule_pattern[i] & rule_mask[i])) &&
                   (capturing || rule_trig_enable[i]);
         if (hits[i]) m_count[i] = m_count[i] + 1'b1;
      end
      if (|hits) m_last_match = m_window;
      if (capturing && (|hits)) m_exp_q.push_back(hits);
      // lock state
      if (resync || (trace_width != m_prev_width)) begin
         m_sync = 1'b0;
      end else if (!m_sync && (m_window[63:48] == `TRACE_SYNC_HEAD) &&
                   (m_window[7:0] == `TRACE_SYNC_TAIL)) begin
         m_sync  = 1'b1;
         m_phase = 1;
      end else if (m_sync) begin
         m_phase++;
      end
      m_prev_width = trace_width;
      // oldest pin bit first, newest ends on top
      for (int k = 0; k < w; k++) begin
         m_window = {data[k], m_window[63:1]};
      end
      @(posedge fe_clk);
      #1;
   endtask

   `include "tb_trace_tests.svh"

   ////////////////////////////////////////
   // sequence
   ////////////////////////////////////////

   initial begin
      seed          = 92122;
      error_count   = 0;
      rec_total     = 0;
      credit_total  = 0;
      trig_pulses   = 0;
      auto_credit   = 1'b1;
      reset         = 1'b1;
      trace_data    = 4'h0;
      trace_width   = 3'd4;
      resync        = 1'b0;
      capturing     = 1'b0;
      arm           = 1'b0;
      rule_enable      = '0;
      rule_trig_enable = '0;
      rec_credit    = 1'b0;
      cfg_width     = 3'd4;
      cfg_resync    = 1'b0;
      cfg_capturing = 1'b0;
      cfg_arm       = 1'b0;
      cfg_enable    = '0;
      cfg_trig      = '0;
      for (int i = 0; i < `TRACE_MATCH_RULES; i++) begin
         rule_pattern[i] = '0;
         rule_mask[i]    = '0;
         cfg_pattern[i]  = '0;
         cfg_mask[i]     = '0;
         m_count[i]      = '0;
      end
      m_window     = '0;
      m_sync       = 1'b0;
      m_phase      = 0;
      m_prev_width = 3'd4;
      m_last_match = '0;
      repeat (8) @(posedge fe_clk);
      @(negedge fe_clk);
      reset = 1'b0;

      sync_lock_test();
      match_count_test();
      trigger_test();
      record_format_test();
      credit_test();

      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+rtl
+incdir+tests
rtl/trace_pkg.sv
rtl/trace_shifter.sv
rtl/trace_sync.sv
rtl/trace_matcher.sv
rtl/trace_packer.sv
rtl/trace_frontend.sv
tests/tb_trace_frontend.sv

// ==== Makefile ====
# Verilator build for the trace front end testbench

TOP       ?= tb_trace_frontend
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
PASS_MSG  := \*\*\* PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
